// File: sim.f
+incdir+bench
hdl/MemSystemTypes.sv
hdl/ReplayQueueTypes.sv
hdl/ReplayHeadIF.sv
hdl/ReplayStorage.sv
hdl/ReplayControl.sv
hdl/MissWaitCheck.sv
hdl/ReplaySquash.sv
hdl/ReplayQueue.sv
bench/ReplayQueueTb.sv

// File: bench/ReplayQueueTbTable.svh
// Stimulus rows for the replay queue testbench, applied in order.
// Columns: intValid, memValid, gap to next record, checkGap, missLoad,
// holdRelease, recovery, flushHead, flushTail.
// missLoad makes mem lane 0 a load waiting on MSHR 0.
// holdRelease lets the queue fill while blocked, then pulses recovery and frees the MSHR.

`ifndef REPLAY_QUEUE_TB_TABLE_SVH
`define REPLAY_QUEUE_TB_TABLE_SVH

typedef struct packed {
    logic [1:0]   intValid;
    logic [1:0]   memValid;
    logic [7:0]   gap;
    logic         checkGap;
    logic         missLoad;
    logic         holdRelease;
    logic         recovery;
    ActiveListPtr flushHead;
    ActiveListPtr flushTail;
} TableRow;

localparam int RowNum = 22;

localparam TableRow Rows [RowNum] = '{
    '{2'b01, 2'b00, 8'd3, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b11, 2'b00, 8'd4, 1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b00, 2'b11, 8'd2, 1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b10, 2'b01, 8'd6, 1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b11, 2'b11, 8'd12, 1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b01, 2'b01, 8'd1, 1'b0, 1'b1, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b10, 2'b00, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b00, 2'b10, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b11, 2'b00, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b01, 2'b10, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b00, 2'b01, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b11, 2'b11, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b10, 2'b10, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b01, 2'b00, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b00, 2'b11, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b10, 2'b01, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b11, 2'b01, 8'd1, 1'b0, 1'b0, 1'b1, 1'b1, 6'd60, 6'd6},
    '{2'b01, 2'b00, 8'd2, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b00, 2'b01, 8'd2, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b11, 2'b00, 8'd2, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b10, 2'b10, 8'd3, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0},
    '{2'b11, 2'b11, 8'd3, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0}
};

string rowName [RowNum] = '{
    "single int lane", "two int lanes", "two mem lanes", "mixed lanes",
    "full group", "miss load at head", "blocked fill 1", "blocked fill 2",
    "blocked fill 3", "blocked fill 4", "blocked fill 5", "blocked fill 6",
    "blocked fill 7", "blocked fill 8", "blocked fill 9", "blocked fill 10",
    "recovery while blocked", "after recovery 1", "after recovery 2",
    "after recovery 3", "after recovery 4", "after flush drained"
};

`endif

// File: bench/ReplayQueueTb.sv
// Testbench for the replay queue.
// Records the table rows, predicts order, spacing and squashing with a model
// queue, and compares every replay cycle against it.

`timescale 1ns/1ps

module ReplayQueueTb
    import MemSystemTypes::*;
    import ReplayQueueTypes::*;
();
    localparam int EntryNum = 16;
    localparam int MaxInterval = 7;
    localparam int StallMargin = 3;
    localparam int IntW = 2;
    localparam int MemW = 2;
    localparam int Timeout = 200;
    localparam int HoldCycles = 20;

    `include "ReplayQueueTbTable.svh"

    typedef struct {
        int row;
        logic [1:0] intValid;
        logic [1:0] memValid;
        IntOp intOps [IntW];
        MemOp memOps [MemW];
        int recCycle;
        int prevRecCycle;
        logic checkGap;
    } Expected;

    logic clk = 1'b0;
    logic rst;
    logic [IntW-1:0] intRecordValid;
    IntOp [IntW-1:0] intRecordOp;
    logic [MemW-1:0] memRecordValid;
    MemOp [MemW-1:0] memRecordOp;
    logic [MshrNum-1:0] mshrValid;
    MshrPhase [MshrNum-1:0] mshrPhase;
    AddrSubset [MshrNum-1:0] mshrAddrSubset;
    logic recoveryValid;
    ActiveListPtr flushHeadPtr;
    ActiveListPtr flushTailPtr;
    logic [IntW-1:0] intReplayValid;
    IntOp [IntW-1:0] intReplayOp;
    logic [MemW-1:0] memReplayValid;
    MemOp [MemW-1:0] memReplayOp;
    logic replay;
    logic stallUpper;
    logic flushedOpExist;

    integer seed = 4239;
    int cycleNum = 0;
    int lastReplayCycle = 0;
    int lastRecCycle = 0;
    int blockCycle = 0;
    int flushRemain = 0;
    logic monitorOn = 1'b0;
    ActiveListPtr expHead;
    ActiveListPtr expTail;
    Expected modelQ [$];

    ReplayQueue #(
        .EntryNum(EntryNum),
        .MaxInterval(MaxInterval),
        .StallMargin(StallMargin),
        .IntWidth(IntW),
        .MemWidth(MemW)
    ) dut (
        .clk(clk),
        .rst(rst),
        .intRecordValid(intRecordValid),
        .intRecordOp(intRecordOp),
        .memRecordValid(memRecordValid),
        .memRecordOp(memRecordOp),
        .mshrValid(mshrValid),
        .mshrPhase(mshrPhase),
        .mshrAddrSubset(mshrAddrSubset),
        .recoveryValid(recoveryValid),
        .flushHeadPtr(flushHeadPtr),
        .flushTailPtr(flushTailPtr),
        .intReplayValid(intReplayValid),
        .intReplayOp(intReplayOp),
        .memReplayValid(memReplayValid),
        .memReplayOp(memReplayOp),
        .replay(replay),
        .stallUpper(stallUpper),
        .flushedOpExist(flushedOpExist)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleNum <= cycleNum + 1;
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (act !== exp) begin
            abortRun($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic checkIntLane(string name, IntOp exp, IntOp act);
        if (act !== exp) begin
            abortRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkMemLane(string name, MemOp exp, MemOp act);
        if (act !== exp) begin
            abortRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkSpacing(string name, int exp, int act);
        if (act != exp) begin
            abortRun($sformatf("mismatch %s expected gap %0d actual gap %0d", name, exp, act));
        end
    endtask

    // Offset from the flush head, counted modulo the active-list size
    function automatic logic ptrFlushed(ActiveListPtr ptr);
        ActiveListPtr offset;
        ActiveListPtr span;
        offset = ptr - expHead;
        span = expTail - expHead;
        return offset < span;
    endfunction

    function automatic ActiveListPtr lanePtr(int row, int lane);
        return ActiveListPtr'((40 + row * 4 + lane) % 64);
    endfunction

    task automatic checkReplay();
        Expected e;
        string name;
        logic squash;
        if (modelQ.size() == 0) begin
            abortRun("replay seen while no recorded group was outstanding");
        end
        e = modelQ.pop_front();
        name = rowName[e.row];
        checkBit({name, " stallUpper"}, 1'b1, stallUpper);
        for (int i = 0; i < IntW; i++) begin
            squash = flushRemain != 0 && ptrFlushed(e.intOps[i].activeListPtr);
            checkBit({name, " int valid"}, e.intValid[i] && !squash, intReplayValid[i]);
            if (e.intValid[i]) begin
                checkIntLane({name, " int op"}, e.intOps[i], intReplayOp[i]);
            end
        end
        for (int i = 0; i < MemW; i++) begin
            squash = flushRemain != 0 && ptrFlushed(e.memOps[i].activeListPtr);
            checkBit({name, " mem valid"}, e.memValid[i] && !squash, memReplayValid[i]);
            if (e.memValid[i]) begin
                checkMemLane({name, " mem op"}, e.memOps[i], memReplayOp[i]);
            end
        end
        if (e.checkGap) begin
            checkSpacing(name, e.recCycle - e.prevRecCycle, cycleNum - lastReplayCycle);
        end
        lastReplayCycle = cycleNum;
        if (flushRemain != 0) begin
            flushRemain--;
        end
    endtask

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (monitorOn) begin
            checkBit("flushedOpExist", flushRemain != 0, flushedOpExist);
            if (replay) begin
                checkReplay();
            end else begin
                for (int i = 0; i < IntW; i++) begin
                    checkBit("idle int valid", 1'b0, intReplayValid[i]);
                end
                for (int i = 0; i < MemW; i++) begin
                    checkBit("idle mem valid", 1'b0, memReplayValid[i]);
                end
            end
        end
    end

    task automatic waitStallLow();
        int waited;
        waited = 0;
        while (stallUpper) begin
            waited++;
            if (waited > Timeout) begin
                abortRun("stallUpper stayed high too long");
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic recordRow(int r);
        Expected e;
        logic [31:0] rnd;
        e.row = r;
        e.intValid = Rows[r].intValid;
        e.memValid = Rows[r].memValid;
        for (int i = 0; i < IntW; i++) begin
            rnd = $random(seed);
            e.intOps[i].activeListPtr = lanePtr(r, i);
            e.intOps[i].tag = rnd[15:0];
        end
        for (int i = 0; i < MemW; i++) begin
            rnd = $random(seed);
            e.memOps[i].activeListPtr = lanePtr(r, IntW + i);
            e.memOps[i].tag = rnd[15:0];
            e.memOps[i].kind = rnd[16] ? MemOpLoad : MemOpStore;
            e.memOps[i].hasMshr = 1'b0;
            e.memOps[i].mshrId = '0;
            e.memOps[i].addrHit = 1'b0;
            e.memOps[i].addrSubset = rnd[20:17];
        end
        if (Rows[r].missLoad) begin
            e.memOps[0].kind = MemOpLoad;
            e.memOps[0].hasMshr = 1'b1;
            mshrPhase[0] = MshrReadWait;
            blockCycle = cycleNum;
        end
        e.recCycle = cycleNum;
        e.prevRecCycle = lastRecCycle;
        e.checkGap = Rows[r].checkGap;
        lastRecCycle = cycleNum;
        intRecordValid = e.intValid;
        memRecordValid = e.memValid;
        for (int i = 0; i < IntW; i++) begin
            intRecordOp[i] = e.intOps[i];
        end
        for (int i = 0; i < MemW; i++) begin
            memRecordOp[i] = e.memOps[i];
        end
        modelQ.push_back(e);
        @(posedge clk);
        #1;
        intRecordValid = '0;
        memRecordValid = '0;
    endtask

    // While the head waits one group is pushed per cycle until the queue is full
    task automatic holdAndRelease(int r);
        int k;
        k = cycleNum - blockCycle;
        while (k < HoldCycles) begin
            @(negedge clk);
            checkBit("blocked replay", 1'b0, replay);
            checkBit("blocked stallUpper", k >= EntryNum - StallMargin, stallUpper);
            @(posedge clk);
            #1;
            k = cycleNum - blockCycle;
        end
        if (Rows[r].recovery) begin
            recoveryValid = 1'b1;
            flushHeadPtr = Rows[r].flushHead;
            flushTailPtr = Rows[r].flushTail;
        end
        @(posedge clk);
        #1;
        recoveryValid = 1'b0;
        if (Rows[r].recovery) begin
            expHead = Rows[r].flushHead;
            expTail = Rows[r].flushTail;
            flushRemain = k < EntryNum ? k : EntryNum;
        end
        mshrPhase[0] = MshrDone;
    endtask

    initial begin
        int waited;
        rst = 1'b1;
        intRecordValid = '0;
        intRecordOp = '0;
        memRecordValid = '0;
        memRecordOp = '0;
        mshrValid = '0;
        for (int i = 0; i < MshrNum; i++) begin
            mshrPhase[i] = MshrDone;
        end
        mshrAddrSubset = '0;
        recoveryValid = 1'b0;
        flushHeadPtr = '0;
        flushTailPtr = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkBit("reset replay", 1'b0, replay);
        checkBit("reset stallUpper", 1'b0, stallUpper);
        checkBit("reset flushedOpExist", 1'b0, flushedOpExist);
        checkBit("reset int valids", 1'b0, |intReplayValid);
        checkBit("reset mem valids", 1'b0, |memReplayValid);
        monitorOn = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        for (int r = 0; r < RowNum; r++) begin
            waitStallLow();
            recordRow(r);
            if (Rows[r].holdRelease) begin
                holdAndRelease(r);
            end else begin
                repeat (Rows[r].gap - 1) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        waited = 0;
        while (modelQ.size() != 0) begin
            waited++;
            if (waited > Timeout) begin
                abortRun("recorded groups were never replayed");
            end
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkBit("final flushedOpExist", 1'b0, flushedOpExist);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: hdl/ReplayQueue.sv
// Replay queue of the issue stage.
// Records issued int and mem groups with their spacing and replays them in order,
// holding the head on pending misses and squashing flushed ops on the way out.

`timescale 1ns/1ps

module ReplayQueue
    import MemSystemTypes::*;
    import ReplayQueueTypes::*;
#(
    parameter int EntryNum = 16,
    parameter int MaxInterval = 7,
    parameter int StallMargin = 3,
    parameter int IntWidth = 2,
    parameter int MemWidth = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic [IntWidth-1:0] intRecordValid,
    input  IntOp [IntWidth-1:0] intRecordOp,
    input  logic [MemWidth-1:0] memRecordValid,
    input  MemOp [MemWidth-1:0] memRecordOp,
    input  logic [MshrNum-1:0] mshrValid,
    input  MshrPhase [MshrNum-1:0] mshrPhase,
    input  AddrSubset [MshrNum-1:0] mshrAddrSubset,
    input  logic recoveryValid,
    input  ActiveListPtr flushHeadPtr,
    input  ActiveListPtr flushTailPtr,
    output logic [IntWidth-1:0] intReplayValid,
    output IntOp [IntWidth-1:0] intReplayOp,
    output logic [MemWidth-1:0] memReplayValid,
    output MemOp [MemWidth-1:0] memReplayOp,
    output logic replay,
    output logic stallUpper,
    output logic flushedOpExist
);
    localparam int IntervalWidth = $clog2(MaxInterval + 1);

    // One issue cycle worth of lanes and the cycles since the previous record
    typedef struct packed {
        IntLane [IntWidth-1:0] intLanes;
        MemLane [MemWidth-1:0] memLanes;
        logic [IntervalWidth-1:0] interval;
    } Group;

    ReplayHeadIF #(.EntryNum(EntryNum), .Group(Group)) headIf ();

    logic [MemWidth-1:0] memWaiting;
    Group popGroup;
    logic popValid;
    logic almostFull;

    ReplayStorage #(
        .EntryNum(EntryNum),
        .StallMargin(StallMargin),
        .Group(Group)
    ) storage (
        .clk(clk),
        .rst(rst),
        .head(headIf.storage),
        .almostFull(almostFull)
    );

    ReplayControl #(
        .EntryNum(EntryNum),
        .MaxInterval(MaxInterval),
        .IntWidth(IntWidth),
        .MemWidth(MemWidth),
        .Group(Group)
    ) control (
        .clk(clk),
        .rst(rst),
        .intRecordValid(intRecordValid),
        .intRecordOp(intRecordOp),
        .memRecordValid(memRecordValid),
        .memRecordOp(memRecordOp),
        .memWaiting(memWaiting),
        .head(headIf.control),
        .popGroup(popGroup),
        .popValid(popValid)
    );

    MissWaitCheck #(.MemWidth(MemWidth)) missCheck (
        .headMemLanes(headIf.headGroup.memLanes),
        .mshrValid(mshrValid),
        .mshrPhase(mshrPhase),
        .mshrAddrSubset(mshrAddrSubset),
        .memWaiting(memWaiting)
    );

    ReplaySquash #(
        .EntryNum(EntryNum),
        .IntWidth(IntWidth),
        .MemWidth(MemWidth),
        .Group(Group)
    ) squash (
        .clk(clk),
        .rst(rst),
        .popGroup(popGroup),
        .popValid(popValid),
        .queueCount(headIf.count),
        .recoveryValid(recoveryValid),
        .flushHeadPtr(flushHeadPtr),
        .flushTailPtr(flushTailPtr),
        .almostFull(almostFull),
        .intReplayValid(intReplayValid),
        .intReplayOp(intReplayOp),
        .memReplayValid(memReplayValid),
        .memReplayOp(memReplayOp),
        .replay(replay),
        .stallUpper(stallUpper),
        .flushedOpExist(flushedOpExist)
    );

endmodule

// File: hdl/ReplaySquash.sv
// Output stage of the replay queue.
// Registers the popped group, snapshots the flush range on recovery
// and drops replayed ops that fall inside it.

`timescale 1ns/1ps

module ReplaySquash
    import ReplayQueueTypes::*;
#(
    parameter int EntryNum = 16,
    parameter int IntWidth = 2,
    parameter int MemWidth = 2,
    parameter type Group = logic,
    localparam int CountWidth = $clog2(EntryNum + 1)
) (
    input  logic clk,
    input  logic rst,
    input  Group popGroup,
    input  logic popValid,
    input  logic [CountWidth-1:0] queueCount,
    input  logic recoveryValid,
    input  ActiveListPtr flushHeadPtr,
    input  ActiveListPtr flushTailPtr,
    input  logic almostFull,
    output logic [IntWidth-1:0] intReplayValid,
    output IntOp [IntWidth-1:0] intReplayOp,
    output logic [MemWidth-1:0] memReplayValid,
    output MemOp [MemWidth-1:0] memReplayOp,
    output logic replay,
    output logic stallUpper,
    output logic flushedOpExist
);
    logic [IntWidth-1:0] intValidReg;
    logic [MemWidth-1:0] memValidReg;
    logic replayReg;
    logic nextReplay;
    logic [CountWidth-1:0] flushCount;
    ActiveListPtr rangeHead;
    ActiveListPtr rangeTail;
    logic flushActive;

    // Range is [lo, hi) and may wrap past the end of the active list
    function automatic logic inFlushRange(ActiveListPtr ptr, ActiveListPtr lo, ActiveListPtr hi);
        if (lo <= hi) begin
            return ptr >= lo && ptr < hi;
        end
        return ptr >= lo || ptr < hi;
    endfunction

    always_comb begin
        nextReplay = 1'b0;
        for (int i = 0; i < IntWidth; i++) begin
            nextReplay |= popGroup.intLanes[i].valid;
        end
        for (int i = 0; i < MemWidth; i++) begin
            nextReplay |= popGroup.memLanes[i].valid;
        end
    end

    // Lane valids arrive already masked with pop
    always_ff @(posedge clk) begin
        if (rst) begin
            intValidReg <= '0;
            memValidReg <= '0;
            replayReg <= 1'b0;
        end else begin
            for (int i = 0; i < IntWidth; i++) begin
                intValidReg[i] <= popGroup.intLanes[i].valid;
            end
            for (int i = 0; i < MemWidth; i++) begin
                memValidReg[i] <= popGroup.memLanes[i].valid;
            end
            replayReg <= nextReplay;
        end
    end

    always_ff @(posedge clk) begin
        if (popValid) begin
            for (int i = 0; i < IntWidth; i++) begin
                intReplayOp[i] <= popGroup.intLanes[i].op;
            end
            for (int i = 0; i < MemWidth; i++) begin
                memReplayOp[i] <= popGroup.memLanes[i].op;
            end
        end
    end

    // Every group queued at recovery time may hold flushed ops
    always_ff @(posedge clk) begin
        if (rst) begin
            flushCount <= '0;
        end else if (recoveryValid) begin
            flushCount <= queueCount;
        end else if (flushActive && replayReg) begin
            flushCount <= flushCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (recoveryValid) begin
            rangeHead <= flushHeadPtr;
            rangeTail <= flushTailPtr;
        end
    end

    assign flushActive = flushCount != '0;

    always_comb begin
        for (int i = 0; i < IntWidth; i++) begin
            intReplayValid[i] = intValidReg[i] && !(flushActive
                && inFlushRange(intReplayOp[i].activeListPtr, rangeHead, rangeTail));
        end
        for (int i = 0; i < MemWidth; i++) begin
            memReplayValid[i] = memValidReg[i] && !(flushActive
                && inFlushRange(memReplayOp[i].activeListPtr, rangeHead, rangeTail));
        end
    end

    assign replay = replayReg;
    assign stallUpper = replayReg || almostFull;
    assign flushedOpExist = flushActive;

    // Snapshot drains through replays, or a new recovery reloads it
    assert property (@(posedge clk) disable iff (rst)
        $fell(flushedOpExist) |-> $past(replay) || $past(recoveryValid));

endmodule

// File: hdl/MissWaitCheck.sv
// Miss check for the loads at the head of the replay queue.
// A lane waits while the MSHR it depends on has no line data yet.

`timescale 1ns/1ps

module MissWaitCheck
    import MemSystemTypes::*;
    import ReplayQueueTypes::*;
#(
    parameter int MemWidth = 2
) (
    input  MemLane [MemWidth-1:0] headMemLanes,
    input  logic [MshrNum-1:0] mshrValid,
    input  MshrPhase [MshrNum-1:0] mshrPhase,
    input  AddrSubset [MshrNum-1:0] mshrAddrSubset,
    output logic [MemWidth-1:0] memWaiting
);

    for (genvar i = 0; i < MemWidth; i++) begin : gLane
        MshrIndex id;
        logic isLoad;
        logic notReady;
        logic ownMiss;
        logic hitMiss;

        assign id = headMemLanes[i].op.mshrId;
        assign isLoad = headMemLanes[i].valid && headMemLanes[i].op.kind == MemOpLoad;
        assign notReady = mshrPhase[id] < MshrWriteCacheReq;

        // Load allocated the MSHR itself
        assign ownMiss = headMemLanes[i].op.hasMshr && notReady;

        // Load found another miss to the same line; the subset confirms
        // the MSHR was not reused in the meantime
        assign hitMiss = headMemLanes[i].op.addrHit && mshrValid[id]
            && mshrAddrSubset[id] == headMemLanes[i].op.addrSubset && notReady;

        assign memWaiting[i] = isLoad && (ownMiss || hitMiss);
    end

endmodule

// File: hdl/ReplayControl.sv
// Push and pop decisions of the replay queue.
// Builds the recorded group, tracks recording and replay spacing,
// and counts the groups that hold at least one valid lane.

`timescale 1ns/1ps

module ReplayControl
    import ReplayQueueTypes::*;
#(
    parameter int EntryNum = 16,
    parameter int MaxInterval = 7,
    parameter int IntWidth = 2,
    parameter int MemWidth = 2,
    parameter type Group = logic,
    localparam int CountWidth = $clog2(EntryNum + 1),
    localparam int IntervalWidth = $clog2(MaxInterval + 1)
) (
    input  logic clk,
    input  logic rst,
    input  logic [IntWidth-1:0] intRecordValid,
    input  IntOp [IntWidth-1:0] intRecordOp,
    input  logic [MemWidth-1:0] memRecordValid,
    input  MemOp [MemWidth-1:0] memRecordOp,
    input  logic [MemWidth-1:0] memWaiting,
    ReplayHeadIF.control head,
    output Group popGroup,
    output logic popValid
);
    localparam logic [IntervalWidth-1:0] IntervalCap = IntervalWidth'(MaxInterval);

    Group recordGroup;
    logic [IntervalWidth-1:0] intervalIn;
    logic [IntervalWidth-1:0] intervalCount;
    logic [CountWidth-1:0] validGroupCount;
    logic recordAny;
    logic headAny;
    logic push;
    logic pop;

    always_comb begin
        recordGroup.interval = intervalIn;
        for (int i = 0; i < IntWidth; i++) begin
            recordGroup.intLanes[i].valid = intRecordValid[i];
            recordGroup.intLanes[i].op = intRecordOp[i];
        end
        for (int i = 0; i < MemWidth; i++) begin
            recordGroup.memLanes[i].valid = memRecordValid[i];
            recordGroup.memLanes[i].op = memRecordOp[i];
        end
    end

    always_comb begin
        headAny = 1'b0;
        popGroup = head.headGroup;
        for (int i = 0; i < IntWidth; i++) begin
            headAny |= head.headGroup.intLanes[i].valid;
            popGroup.intLanes[i].valid = pop && head.headGroup.intLanes[i].valid;
        end
        for (int i = 0; i < MemWidth; i++) begin
            headAny |= head.headGroup.memLanes[i].valid;
            popGroup.memLanes[i].valid = pop && head.headGroup.memLanes[i].valid;
        end
    end

    assign recordAny = |intRecordValid || |memRecordValid;

    // Empty spacer groups keep the spacing only while valid groups are queued
    assign push = !head.full && (recordAny || validGroupCount != '0);
    // memWaiting already covers valid loads only, so an empty head goes on spacing alone
    assign pop = !head.empty && intervalCount >= head.headGroup.interval && !(|memWaiting);

    assign head.push = push;
    assign head.pop = pop;
    assign head.recordGroup = recordGroup;
    assign popValid = pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            validGroupCount <= '0;
            intervalIn <= '0;
            intervalCount <= '0;
        end else begin
            case ({push && recordAny, pop && headAny})
                2'b10: validGroupCount <= validGroupCount + 1'b1;
                2'b01: validGroupCount <= validGroupCount - 1'b1;
                default: validGroupCount <= validGroupCount;
            endcase
            if (push) begin
                intervalIn <= '0;
            end else if (intervalIn < IntervalCap) begin
                intervalIn <= intervalIn + 1'b1;
            end
            if (pop) begin
                intervalCount <= '0;
            end else if (intervalCount < IntervalCap) begin
                intervalCount <= intervalCount + 1'b1;
            end
        end
    end

    // A valid group leaving the head was counted when it was recorded
    assert property (@(posedge clk) disable iff (rst) pop && headAny |-> validGroupCount != '0);

endmodule

// File: hdl/ReplayStorage.sv
// Circular buffer of recorded groups.
// Written at the tail on push, read combinationally at the head.
// almostFull asks the upper stages to stop before records get lost.

`timescale 1ns/1ps

module ReplayStorage #(
    parameter int EntryNum = 16,
    parameter int StallMargin = 3,
    parameter type Group = logic,
    localparam int CountWidth = $clog2(EntryNum + 1)
) (
    input  logic clk,
    input  logic rst,
    ReplayHeadIF.storage head,
    output logic almostFull
);
    localparam int PtrWidth = $clog2(EntryNum);
    localparam logic [CountWidth-1:0] FullLevel = CountWidth'(EntryNum);
    localparam logic [CountWidth-1:0] StallLevel = CountWidth'(EntryNum - StallMargin);

    Group groups [EntryNum];
    logic [PtrWidth-1:0] headPtr;
    logic [PtrWidth-1:0] tailPtr;
    logic [CountWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (head.push) begin
            groups[tailPtr] <= head.recordGroup;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (head.push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (head.pop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({head.push, head.pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head.headGroup = groups[headPtr];
    assign head.empty = count == '0;
    assign head.full = count == FullLevel;
    assign head.count = count;

    // Room left for records already in flight when the stall takes effect
    assign almostFull = count >= StallLevel;

    // Control has to drop records rather than overwrite the head
    assert property (@(posedge clk) disable iff (rst) head.full |-> !head.push);

endmodule

// File: hdl/ReplayHeadIF.sv
// Link between the replay buffer and its control.
// Control drives push, pop and the recorded group; the buffer answers with its head.

`timescale 1ns/1ps

interface ReplayHeadIF #(
    parameter int EntryNum = 16,
    parameter type Group = logic
);
    localparam int CountWidth = $clog2(EntryNum + 1);

    logic push;
    logic pop;
    Group recordGroup;
    Group headGroup;
    logic empty;
    logic full;
    logic [CountWidth-1:0] count;

    modport storage (
        input  push, pop, recordGroup,
        output headGroup, empty, full, count
    );

    modport control (
        output push, pop, recordGroup,
        input  headGroup, empty, full, count
    );

endinterface

// File: hdl/ReplayQueueTypes.sv
// Op payloads and lane records kept by the replay queue.
// The recorded group depends on the lane counts and is built at the top level.

package ReplayQueueTypes;
    import MemSystemTypes::*;

    // Flush ranges over this pointer wrap around
    typedef logic [5:0] ActiveListPtr;

    typedef struct packed {
        ActiveListPtr activeListPtr;
        logic [15:0]  tag;
    } IntOp;

    typedef struct packed {
        ActiveListPtr activeListPtr;
        logic [15:0]  tag;
        MemOpKind     kind;
        // Load allocated its own MSHR
        logic         hasMshr;
        MshrIndex     mshrId;
        // Load matched a pending MSHR at address check
        logic         addrHit;
        AddrSubset    addrSubset;
    } MemOp;

    typedef struct packed {
        logic valid;
        IntOp op;
    } IntLane;

    typedef struct packed {
        logic valid;
        MemOp op;
    } MemLane;

endpackage

// File: hdl/MemSystemTypes.sv
// Memory-side definitions seen by the replay queue.
// Memory op kinds, MSHR progress and the types used to look an MSHR up.

package MemSystemTypes;

    typedef enum logic [1:0] {
        MemOpLoad  = 2'd0,
        MemOpStore = 2'd1
    } MemOpKind;

    // Line data is available from MshrWriteCacheReq onward
    typedef enum logic [2:0] {
        MshrIdle          = 3'd0,
        MshrReadReq       = 3'd1,
        MshrReadWait      = 3'd2,
        MshrWriteCacheReq = 3'd3,
        MshrDone          = 3'd4
    } MshrPhase;

    localparam int MshrNum = 4;

    typedef logic [$clog2(MshrNum)-1:0] MshrIndex;

    // Slice of the cache index that tells whether an MSHR still serves the same miss
    typedef logic [3:0] AddrSubset;

endpackage
